// File: common/aes_dec_pkg.sv
//------------------------------
// Shared types, constants and GF(2^8) helpers for the AES decipher
// round engine. Modules refer to these by scoped names.
//------------------------------

package aes_dec_pkg;

  //------------------------------
  // Types
  //------------------------------
  // Cipher state, word 0 in the top bits
  typedef logic [127:0] block_t;
  typedef logic [31:0]  word_t;
  typedef logic [3:0]   round_t;
  typedef logic [1:0]   sword_t;

  typedef enum logic {KEYLEN_128, KEYLEN_256} keylen_t;

  typedef enum logic [1:0] {CTRL_IDLE, CTRL_INIT, CTRL_SBOX, CTRL_MAIN} ctrl_state_t;

  // Datapath operation for the current cycle
  typedef enum logic [2:0] {UPD_NONE, UPD_INIT, UPD_SBOX, UPD_MAIN, UPD_FINAL} update_t;

  //------------------------------
  // Constants
  //------------------------------
  localparam round_t AES128_ROUNDS = 4'd10;
  localparam round_t AES256_ROUNDS = 4'd14;

  // Low byte of x^8 + x^4 + x^3 + x + 1
  localparam logic [7:0] GF_POLY = 8'h1b;

  //------------------------------
  // Functions
  //------------------------------
  // Multiply by x, reduce on carry out
  function automatic logic [7:0] gf_mul2(input logic [7:0] op);
    gf_mul2 = {op[6:0], 1'b0} ^ (GF_POLY & {8{op[7]}});
  endfunction

  // Shift-and-add product of two field elements
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ p;
      p = gf_mul2(p);
    end
    gf_mul = acc;
  endfunction

  // One column times the inverse MixColumns matrix {0e 0b 0d 09}
  function automatic word_t inv_mixw(input word_t w);
    logic [7:0] b0, b1, b2, b3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    inv_mixw[31:24] = gf_mul(b0, 8'h0e) ^ gf_mul(b1, 8'h0b) ^ gf_mul(b2, 8'h0d) ^ gf_mul(b3, 8'h09);
    inv_mixw[23:16] = gf_mul(b0, 8'h09) ^ gf_mul(b1, 8'h0e) ^ gf_mul(b2, 8'h0b) ^ gf_mul(b3, 8'h0d);
    inv_mixw[15:8]  = gf_mul(b0, 8'h0d) ^ gf_mul(b1, 8'h09) ^ gf_mul(b2, 8'h0e) ^ gf_mul(b3, 8'h0b);
    inv_mixw[7:0]   = gf_mul(b0, 8'h0b) ^ gf_mul(b1, 8'h0d) ^ gf_mul(b2, 8'h09) ^ gf_mul(b3, 8'h0e);
  endfunction

  function automatic block_t inv_mixcolumns(input block_t data);
    for (int c = 0; c < 4; c++)
      inv_mixcolumns[127 - 32*c -: 32] = inv_mixw(data[127 - 32*c -: 32]);
  endfunction

  // Row r rotates right by r columns
  function automatic block_t inv_shiftrows(input block_t data);
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
        inv_shiftrows[127 - 32*c - 8*r -: 8] = data[127 - 32*((c - r + 4) % 4) - 8*r -: 8];
    end
  endfunction

endpackage

// File: round_datapath/inv_sbox_word.sv
//------------------------------
// Computed inverse S-box on one 32-bit word, four bytes in parallel.
// Purely combinational, inverse affine step then field inversion.
//------------------------------
`timescale 1ns/100ps

module inv_sbox_word (
  input  aes_dec_pkg::word_t sbox_in,
  output aes_dec_pkg::word_t sbox_out
);

  //------------------------------
  // Byte transform
  //------------------------------
  // Inverse of the S-box affine map
  function automatic logic [7:0] inv_affine(input logic [7:0] b);
    logic [7:0] r1, r3, r6;
    r1 = {b[6:0], b[7]};
    r3 = {b[4:0], b[7:5]};
    r6 = {b[1:0], b[7:2]};
    inv_affine = r1 ^ r3 ^ r6 ^ 8'h05;
  endfunction

  // x^254 by square and multiply, zero stays zero
  function automatic logic [7:0] gf_inv(input logic [7:0] x);
    logic [7:0] acc;
    logic [7:0] sq;
    acc = 8'h01;
    sq  = x;
    // Collect x^2, x^4 up to x^128
    for (int i = 1; i < 8; i++)
    begin
      sq  = aes_dec_pkg::gf_mul(sq, sq);
      acc = aes_dec_pkg::gf_mul(acc, sq);
    end
    gf_inv = acc;
  endfunction

  //------------------------------
  // Four byte lanes
  //------------------------------
  genvar g;
  generate
    for (g = 0; g < 4; g++)
    begin : g_lane
      logic [7:0] lane_in;
      logic [7:0] lane_aff;

      assign lane_in  = sbox_in[31 - 8*g -: 8];
      assign lane_aff = inv_affine(lane_in);

      // Input 0x00 gives 0x05 here, whose inverse is 0x52
      assign sbox_out[31 - 8*g -: 8] = gf_inv(lane_aff);
    end
  endgenerate

endmodule

// File: round_datapath/round_datapath.sv
//------------------------------
// State register and round transforms of the decipher engine.
// The controller's update code picks what is written each cycle.
//------------------------------
`timescale 1ns/100ps

module round_datapath (
  input  logic                 clk,
  input  logic                 reset_n,
  input  aes_dec_pkg::update_t update,
  input  aes_dec_pkg::sword_t  sword,
  input  aes_dec_pkg::block_t  round_key,
  input  aes_dec_pkg::block_t  block,
  output aes_dec_pkg::block_t  new_block
);

  //------------------------------
  // State and S-box path
  //------------------------------
  // Four columns, index 0 is the top word of the block
  aes_dec_pkg::word_t state_w [4];

  // Per-word write enables, bit i for word i
  logic [3:0] word_we;

  aes_dec_pkg::block_t old_block;
  aes_dec_pkg::block_t block_new;

  aes_dec_pkg::word_t sbox_in;
  aes_dec_pkg::word_t sbox_out;

  assign old_block = {state_w[0], state_w[1], state_w[2], state_w[3]};
  assign new_block = old_block;

  // Word currently being substituted
  assign sbox_in = state_w[sword];

  inv_sbox_word u_inv_sbox (
    .sbox_in  (sbox_in),
    .sbox_out (sbox_out)
  );

  //------------------------------
  // Round logic
  //------------------------------
  always_comb
  begin
    block_new = '0;
    word_we   = 4'b0000;

    case (update)
      aes_dec_pkg::UPD_INIT:
      begin
        // Last round key, then undo ShiftRows
        block_new = aes_dec_pkg::inv_shiftrows(block ^ round_key);
        word_we   = 4'b1111;
      end

      aes_dec_pkg::UPD_SBOX:
      begin
        // Same word on all lanes, enable picks the target
        block_new      = {4{sbox_out}};
        word_we[sword] = 1'b1;
      end

      aes_dec_pkg::UPD_MAIN:
      begin
        block_new = aes_dec_pkg::inv_shiftrows(
                      aes_dec_pkg::inv_mixcolumns(old_block ^ round_key));
        word_we   = 4'b1111;
      end

      aes_dec_pkg::UPD_FINAL:
      begin
        // Round key 0 gives the plaintext
        block_new = old_block ^ round_key;
        word_we   = 4'b1111;
      end

      default:
      begin
        word_we = 4'b0000;
      end
    endcase
  end

  //------------------------------
  // Register update
  //------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < 4; i++)
        state_w[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (word_we[i])
          state_w[i] <= block_new[127 - 32*i -: 32];
      end
    end
  end

endmodule

// File: decipher_ctrl/decipher_ctrl.sv
//------------------------------
// Control FSM for the decipher engine. Runs INIT, then per round four
// S-box word cycles and one MAIN cycle, counting the round index down.
//------------------------------
`timescale 1ns/100ps

module decipher_ctrl (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 next,
  input  aes_dec_pkg::keylen_t keylen,
  output aes_dec_pkg::round_t  round,
  output aes_dec_pkg::update_t update,
  output aes_dec_pkg::sword_t  sword,
  output logic                 ready
);

  //------------------------------
  // Registers and next values
  //------------------------------
  aes_dec_pkg::ctrl_state_t state_reg;
  aes_dec_pkg::ctrl_state_t state_new;

  aes_dec_pkg::round_t round_reg;
  aes_dec_pkg::round_t round_new;

  aes_dec_pkg::sword_t sword_reg;
  aes_dec_pkg::sword_t sword_new;

  logic ready_reg;
  logic ready_new;

  // Set after the final update, raises ready one cycle later
  logic finish_reg;
  logic finish_new;

  // Round count for the selected key length
  aes_dec_pkg::round_t num_rounds;

  assign num_rounds = (keylen == aes_dec_pkg::KEYLEN_256) ? aes_dec_pkg::AES256_ROUNDS
                                                          : aes_dec_pkg::AES128_ROUNDS;

  assign round = round_reg;
  assign sword = sword_reg;
  assign ready = ready_reg;

  //------------------------------
  // State update
  //------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_reg  <= aes_dec_pkg::CTRL_IDLE;
      round_reg  <= '0;
      sword_reg  <= '0;
      ready_reg  <= 1'b1;
      finish_reg <= 1'b0;
    end
    else
    begin
      state_reg  <= state_new;
      round_reg  <= round_new;
      sword_reg  <= sword_new;
      ready_reg  <= ready_new;
      finish_reg <= finish_new;
    end
  end

  //------------------------------
  // Next-state and update decode
  //------------------------------
  always_comb
  begin
    state_new  = state_reg;
    round_new  = round_reg;
    sword_new  = sword_reg;
    ready_new  = ready_reg;
    finish_new = 1'b0;
    update     = aes_dec_pkg::UPD_NONE;

    // Result has been in the state register for a cycle
    if (finish_reg)
      ready_new = 1'b1;

    case (state_reg)
      aes_dec_pkg::CTRL_IDLE:
      begin
        // Start accepted only while idle and ready
        if (next && ready_reg)
        begin
          ready_new = 1'b0;
          round_new = num_rounds;
          state_new = aes_dec_pkg::CTRL_INIT;
        end
      end

      aes_dec_pkg::CTRL_INIT:
      begin
        update    = aes_dec_pkg::UPD_INIT;
        sword_new = '0;
        state_new = aes_dec_pkg::CTRL_SBOX;
      end

      aes_dec_pkg::CTRL_SBOX:
      begin
        update    = aes_dec_pkg::UPD_SBOX;
        sword_new = sword_reg + 2'd1;
        // Last word of the round, step to the next key
        if (sword_reg == 2'd3)
        begin
          round_new = round_reg - 4'd1;
          state_new = aes_dec_pkg::CTRL_MAIN;
        end
      end

      aes_dec_pkg::CTRL_MAIN:
      begin
        sword_new = '0;
        if (round_reg != 4'd0)
        begin
          update    = aes_dec_pkg::UPD_MAIN;
          state_new = aes_dec_pkg::CTRL_SBOX;
        end
        else
        begin
          // Round key 0, only AddRoundKey remains
          update     = aes_dec_pkg::UPD_FINAL;
          finish_new = 1'b1;
          state_new  = aes_dec_pkg::CTRL_IDLE;
        end
      end

      default:
      begin
        state_new = aes_dec_pkg::CTRL_IDLE;
      end
    endcase
  end

endmodule

// File: hdl/aes_decipher_block.sv
//------------------------------
// Top level of the iterative AES inverse-cipher round engine.
// Pulse next while ready is high; round selects the external round key.
//------------------------------
`timescale 1ns/100ps

module aes_decipher_block (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                next,
  input  aes_dec_pkg::keylen_t keylen,
  output aes_dec_pkg::round_t round,
  input  aes_dec_pkg::block_t round_key,
  input  aes_dec_pkg::block_t block,
  output aes_dec_pkg::block_t new_block,
  output logic                ready
);

  // Controller to datapath
  aes_dec_pkg::update_t update;
  aes_dec_pkg::sword_t  sword;

  // Sequencing of rounds and S-box words
  decipher_ctrl u_ctrl (
    .clk     (clk),
    .reset_n (reset_n),
    .next    (next),
    .keylen  (keylen),
    .round   (round),
    .update  (update),
    .sword   (sword),
    .ready   (ready)
  );

  // State register and round transforms
  round_datapath u_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .update    (update),
    .sword     (sword),
    .round_key (round_key),
    .block     (block),
    .new_block (new_block)
  );

endmodule

// File: tb/aes_decipher_properties.sv
//------------------------------
// Concurrent checks on the decipher top level, bound from the testbench
//------------------------------
`timescale 1ns/100ps

module aes_decipher_properties (
  input logic                clk,
  input logic                reset_n,
  input logic                next,
  input logic                ready,
  input aes_dec_pkg::round_t round,
  input aes_dec_pkg::block_t new_block
);

  // Accepted start drops ready on the same edge
  a_ready_falls: assert property (@(posedge clk) disable iff (!reset_n)
    (next && ready) |=> !ready)
    else $error("ready stayed high after an accepted start");

  // AES-256 is the longest schedule
  a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
    round <= 4'd14)
    else $error("round index above 14");

  // Result held while idle
  a_result_held: assert property (@(posedge clk) disable iff (!reset_n)
    (ready && !next) |=> $stable(new_block))
    else $error("new_block changed while idle");

endmodule

// File: tb/tb_aes_model.svh
//------------------------------
// Reference inverse cipher for the decipher testbench, with its own
// inverse S-box table and the FIPS-197 AES-128 example vector.
// Included inside the testbench module.
//------------------------------
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// FIPS-197 appendix C.1 example, key 000102...0f
localparam aes_dec_pkg::block_t FIPS_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
localparam aes_dec_pkg::block_t FIPS_PT = 128'h00112233445566778899aabbccddeeff;

// Expanded key schedule, round 0 first
localparam aes_dec_pkg::block_t FIPS_KEYS [11] = '{
  128'h000102030405060708090a0b0c0d0e0f,
  128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
  128'hb692cf0b643dbdf1be9bc5006830b3fe,
  128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
  128'h47f7f7bc95353e03f96c32bcfd058dfd,
  128'h3caaa3e8a99f9deb50f3af57adf622aa,
  128'h5e390f7df7a69296a7553dc10aa31f6b,
  128'h14f9701ae35fe28c440adf4d4ea9c026,
  128'h47438735a41c65b9e016baf4aebf7ad2,
  128'h549932d1f08557681093ed9cbe2c974e,
  128'h13111d7fe3944a17f307a78b4d2b30c5
};

// Inverse S-box, entry 0 in the top byte
localparam logic [2047:0] INV_SBOX_TBL = {
  128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
  128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
  128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
  128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
  128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
  128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
  128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
  128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
};

function automatic logic [7:0] model_inv_sbox(input logic [7:0] x);
  return INV_SBOX_TBL[2047 - 8*int'(x) -: 8];
endfunction

// Field product by repeated doubling
function automatic logic [7:0] model_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] acc;
  p   = a;
  acc = 8'h00;
  for (int i = 0; i < 8; i++)
  begin
    if (b[i])
      acc = acc ^ p;
    p = p[7] ? ((p << 1) ^ 8'h1b) : (p << 1);
  end
  return acc;
endfunction

// Textbook inverse cipher over nr rounds, keys[nr] applied first
function automatic aes_dec_pkg::block_t model_decrypt(input aes_dec_pkg::block_t ct,
                                                      input aes_dec_pkg::block_t keys [15],
                                                      input int nr);
  logic [7:0] s [16];
  logic [7:0] t [16];
  logic [7:0] a [4];
  aes_dec_pkg::block_t st;
  st = ct ^ keys[nr];
  for (int r = nr - 1; r >= 0; r--)
  begin
    for (int i = 0; i < 16; i++)
      s[i] = st[127 - 8*i -: 8];
    // Byte i sits in row i%4, column i/4; rows rotate right, then substitute
    for (int i = 0; i < 16; i++)
      t[i] = model_inv_sbox(s[4*((i/4 + 4 - i%4) % 4) + i%4]) ^ keys[r][127 - 8*i -: 8];
    // Inverse MixColumns on all but the last round
    if (r > 0)
    begin
      for (int c = 0; c < 4; c++)
      begin
        for (int k = 0; k < 4; k++)
          a[k] = t[4*c + k];
        for (int k = 0; k < 4; k++)
          t[4*c + k] = model_mul(a[k], 8'h0e) ^ model_mul(a[(k + 1) % 4], 8'h0b)
                     ^ model_mul(a[(k + 2) % 4], 8'h0d) ^ model_mul(a[(k + 3) % 4], 8'h09);
      end
    end
    for (int i = 0; i < 16; i++)
      st[127 - 8*i -: 8] = t[i];
  end
  return st;
endfunction

`endif

// File: tb/tb_aes_decipher.sv
//------------------------------
// Testbench for the AES decipher engine. Applies a table of FIPS and
// random AES-256 rows back to back, with a round-key store on round.
//------------------------------
`timescale 1ns/100ps

module tb_aes_decipher;

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_ROWS    = 6;
  localparam int WATCHDOG_NS = 2 * NUM_ROWS * 72 * CLK_PERIOD;

  typedef enum logic {SRC_FIPS, SRC_RANDOM} key_src_t;

  // One test: key length, ciphertext, key source, plaintext, latency, stray start
  typedef struct {
    aes_dec_pkg::keylen_t keylen;
    aes_dec_pkg::block_t  ct;
    key_src_t             key_src;
    aes_dec_pkg::block_t  expected;
    int                   latency;
    logic                 mid_next;
  } test_row_t;

  logic                 clk;
  logic                 reset_n;
  logic                 next;
  aes_dec_pkg::keylen_t keylen;
  aes_dec_pkg::round_t  round;
  aes_dec_pkg::block_t  round_key;
  aes_dec_pkg::block_t  block;
  aes_dec_pkg::block_t  new_block;
  logic                 ready;

  test_row_t           rows [NUM_ROWS];
  aes_dec_pkg::block_t row_keys [NUM_ROWS][15];
  int                  cur_row;
  logic [31:0]         rng_state;

  `include "tb_aes_model.svh"

  // Key store, answers the current round combinationally
  assign round_key = row_keys[cur_row][round];

  aes_decipher_block u_dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .round     (round),
    .round_key (round_key),
    .block     (block),
    .new_block (new_block),
    .ready     (ready)
  );

  bind aes_decipher_block aes_decipher_properties u_props (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .ready     (ready),
    .round     (round),
    .new_block (new_block)
  );

  //------------------------------
  // Random source and compares
  //------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Four fresh words from the generator
  function automatic aes_dec_pkg::block_t random_block();
    aes_dec_pkg::block_t b;
    for (int w = 0; w < 4; w++)
    begin
      rng_state = xorshift32(rng_state);
      b[127 - 32*w -: 32] = rng_state;
    end
    return b;
  endfunction

  task automatic check_block(input string name, input aes_dec_pkg::block_t got,
                             input aes_dec_pkg::block_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "block mismatch");
    end
  endtask

  task automatic check_round(input string name, input aes_dec_pkg::round_t got,
                             input aes_dec_pkg::round_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "round mismatch");
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "latency mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  //------------------------------
  // Stimulus table
  //------------------------------
  task automatic build_table();
    aes_dec_pkg::block_t kset [15];
    rows[0] = '{aes_dec_pkg::KEYLEN_128, FIPS_CT, SRC_FIPS, FIPS_PT, 52, 1'b0};
    rows[1] = '{aes_dec_pkg::KEYLEN_128, FIPS_CT, SRC_FIPS, FIPS_PT, 52, 1'b1};
    rows[2] = '{aes_dec_pkg::KEYLEN_256, '0, SRC_RANDOM, '0, 72, 1'b0};
    rows[3] = '{aes_dec_pkg::KEYLEN_256, '0, SRC_RANDOM, '0, 72, 1'b0};
    rows[4] = '{aes_dec_pkg::KEYLEN_256, '0, SRC_RANDOM, '0, 72, 1'b1};
    rows[5] = '{aes_dec_pkg::KEYLEN_256, '0, SRC_RANDOM, '0, 72, 1'b0};
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      for (int k = 0; k < 15; k++)
        kset[k] = (rows[i].key_src == SRC_FIPS && k < 11) ? FIPS_KEYS[k] : random_block();
      // Random rows get their ciphertext and model plaintext here
      if (rows[i].key_src == SRC_RANDOM)
      begin
        rows[i].ct       = random_block();
        rows[i].expected = model_decrypt(rows[i].ct, kset, 14);
      end
      for (int k = 0; k < 15; k++)
        row_keys[i][k] = kset[k];
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog sized from the longest schedule per row
  initial
  begin
    #(WATCHDOG_NS);
    $display("Run timed out waiting for ready");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  //------------------------------
  // Main sequence
  //------------------------------
  initial
  begin
    int                  n_rounds;
    int                  cycles;
    aes_dec_pkg::round_t min_round;
    reset_n   = 1'b0;
    next      = 1'b0;
    keylen    = aes_dec_pkg::KEYLEN_128;
    block     = '0;
    cur_row   = 0;
    rng_state = 32'd79;
    build_table();
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    check_flag("ready", ready, 1'b1);
    check_block("new_block", new_block, '0);
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      // Start goes out in the cycle right after the previous result
      cur_row = i;
      keylen  = rows[i].keylen;
      block   = rows[i].ct;
      next    = 1'b1;
      @(negedge clk);
      next     = 1'b0;
      n_rounds = (rows[i].keylen == aes_dec_pkg::KEYLEN_256) ? 14 : 10;
      check_flag("ready", ready, 1'b0);
      check_round("round", round, aes_dec_pkg::round_t'(n_rounds));
      cycles    = 0;
      min_round = round;
      while (!ready)
      begin
        @(negedge clk);
        cycles++;
        // Stray start in mid run, must be ignored
        next = rows[i].mid_next && (cycles == 20);
        if (!ready && round < min_round)
          min_round = round;
      end
      check_latency("ready latency", cycles, rows[i].latency);
      check_block("new_block", new_block, rows[i].expected);
      check_round("round minimum", min_round, '0);
    end
    @(negedge clk);
    check_block("new_block", new_block, rows[NUM_ROWS - 1].expected);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: all.f
+incdir+tb
common/aes_dec_pkg.sv
round_datapath/inv_sbox_word.sv
round_datapath/round_datapath.sv
decipher_ctrl/decipher_ctrl.sv
hdl/aes_decipher_block.sv
tb/aes_decipher_properties.sv
tb/tb_aes_decipher.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the decipher testbench with Verilator.
# Exit status is nonzero when the simulation ends in $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_aes_decipher \
  -Mdir obj_dir \
  -f all.f

./obj_dir/Vtb_aes_decipher
